// File: Bender.yml
package:
  name: write_dispatcher

sources:
  - src/dma_pkg.sv
  - src/descriptor_fifo.sv
  - src/write_descriptor_decode.sv
  - src/write_command_issue.sv
  - src/write_response_irq.sv
  - src/write_dispatcher.sv
  - target: simulation
    files:
      - sim/tb_write_dispatcher.sv

// File: sim/tb_write_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module tb_write_dispatcher;

  import dma_pkg::*;

  // Five tests of up to 40 descriptors at about 20 cycles each
  localparam int MAX_CYCLES = 4000;

  logic             clk;
  logic             rst_n;
  logic             stop;
  logic             sw_reset;
  logic             irq_clear;
  logic             desc_req;
  logic [255:0]     desc_data;
  logic             cmd_ack;
  logic             rsp_req;
  write_rsp_t       rsp;
  logic             desc_ack;
  logic             cmd_req;
  write_cmd_t       cmd;
  logic [255:0]     command_word;
  logic             rsp_ack;
  logic             irq;
  dispatch_status_t status;

  integer      seed;
  int          cycle_count;
  int          err_count;
  int          pass_count;
  int          test_errs;
  string       test_name;
  logic [15:0] seq_q [$];
  logic [15:0] exp_completed;
  logic [7:0]  exp_error;
  logic [15:0] exp_last_seq;

  write_dispatcher #(
    .DESC_WIDTH     (256),
    .FIFO_DEPTH     (4),
    .INFLIGHT_DEPTH (4)
  ) u_write_dispatcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .stop         (stop),
    .sw_reset     (sw_reset),
    .irq_clear    (irq_clear),
    .desc_req     (desc_req),
    .desc_data    (desc_data),
    .cmd_ack      (cmd_ack),
    .rsp_req      (rsp_req),
    .rsp          (rsp),
    .desc_ack     (desc_ack),
    .cmd_req      (cmd_req),
    .cmd          (cmd),
    .command_word (command_word),
    .rsp_ack      (rsp_ack),
    .irq          (irq),
    .status       (status)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Cycle limit of %0d reached, a handshake never completed", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Reference model of the extended layout
  // ----------------------------------------------------------
  function automatic logic [255:0] rand_desc();
    logic [255:0] d;
    for (int i = 0; i < 8; i++)
      d[i*32 +: 32] = $random(seed);
    return d;
  endfunction

  function automatic logic [255:0] with_masks(input logic [255:0] d, input logic tc,
                                              input logic et, input logic [7:0] err);
    logic [255:0] r;
    r          = d;
    r[238]     = tc;
    r[239]     = et;
    r[247:240] = err;
    return r;
  endfunction

  function automatic write_cmd_t expect_cmd(input logic [255:0] d, input logic stop_bit,
                                            input logic reset_bit);
    write_cmd_t c;
    c.address         = {d[223:192], d[63:32]};
    c.length          = d[95:64];
    c.burst_count     = d[127:120];
    c.stride          = d[159:144];
    c.sequence_number = d[111:96];
    c.park            = d[235];
    c.end_on_eop      = d[236];
    c.stop            = stop_bit;
    c.sw_reset        = reset_bit;
    return c;
  endfunction

  // Bit 65 stays clear in the master word
  function automatic logic [255:0] expect_word(input logic [255:0] d, input logic stop_bit,
                                               input logic reset_bit);
    logic [255:0] w;
    w          = '0;
    w[31:0]    = d[63:32];
    w[63:32]   = d[95:64];
    w[64]      = d[236];
    w[66]      = stop_bit;
    w[67]      = reset_bit;
    w[75:68]   = d[127:120];
    w[91:76]   = d[159:144];
    w[123:92]  = d[223:192];
    return w;
  endfunction

  function automatic dispatch_status_t status_expect(input logic busy, input logic [3:0] pending);
    dispatch_status_t s;
    s.busy          = busy;
    s.pending       = pending;
    s.completed     = exp_completed;
    s.error_latched = exp_error;
    s.last_sequence = exp_last_seq;
    return s;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic compare_cmd(input string what, input write_cmd_t exp, input write_cmd_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_status(input string what, input dispatch_status_t exp,
                                input dispatch_status_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_word(input string what, input logic [255:0] exp,
                              input logic [255:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  // ----------------------------------------------------------
  // Bus models
  // ----------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic send_descriptor(input logic [255:0] d);
    desc_data = d;
    desc_req  = 1'b1;
    seq_q.push_back(d[111:96]);
    while (desc_ack !== 1'b1)
      tick();
    desc_req = 1'b0;
    while (desc_ack !== 1'b0)
      tick();
  endtask

  task automatic serve_command(output write_cmd_t got);
    while (cmd_req !== 1'b1)
      tick();
    got     = cmd;
    cmd_ack = 1'b1;
    while (cmd_req !== 1'b0)
      tick();
    cmd_ack = 1'b0;
    // Issue block returns to IDLE once it sees ack low
    tick();
  endtask

  task automatic send_response(input write_rsp_t r);
    rsp     = r;
    rsp_req = 1'b1;
    while (rsp_ack !== 1'b1)
      tick();
    rsp_req = 1'b0;
    while (rsp_ack !== 1'b0)
      tick();
    exp_completed = exp_completed + 16'd1;
    exp_error     = exp_error | r.error;
    if (seq_q.size() == 0)
    begin
      $display("%s: a response arrived with no command outstanding", test_name);
      err_count++;
    end
    else
      exp_last_seq = seq_q.pop_front();
  endtask

  task automatic clear_irq();
    irq_clear = 1'b1;
    tick();
    irq_clear = 1'b0;
  endtask

  task automatic expect_no_cmd(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      tick();
      compare_bit("cmd_req held", 1'b0, cmd_req);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_errs)
    begin
      pass_count++;
      $display("%s passed", test_name);
    end
    else
      $display("%s failed with %0d errors", test_name, err_count - test_errs);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_after_reset();
    start_test("after_reset");
    compare_bit("desc_ack", 1'b0, desc_ack);
    compare_bit("cmd_req", 1'b0, cmd_req);
    compare_bit("rsp_ack", 1'b0, rsp_ack);
    compare_bit("irq", 1'b0, irq);
    compare_status("status", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  task automatic test_field_decode();
    logic [255:0] d;
    write_cmd_t   got;
    int           n;
    start_test("field_decode");
    for (n = 0; n < 6; n++)
    begin
      d    = rand_desc();
      stop = 1'b1;
      send_descriptor(d);
      // FIFO head drives the debug word
      compare_word("command_word", expect_word(d, 1'b1, 1'b0), command_word);
      stop = 1'b0;
      serve_command(got);
      compare_cmd("cmd", expect_cmd(d, 1'b0, 1'b0), got);
      send_response({1'b0, 8'h00});
    end
    compare_status("status", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  task automatic test_order_stop();
    logic [255:0] d [3];
    write_cmd_t   got;
    int           n;
    start_test("order_stop");
    stop = 1'b1;
    for (n = 0; n < 3; n++)
    begin
      d[n] = rand_desc();
      send_descriptor(d[n]);
    end
    expect_no_cmd(10);
    // Stop rises again during LOAD, so the first command carries it
    stop = 1'b0;
    tick();
    stop = 1'b1;
    serve_command(got);
    compare_cmd("cmd 0", expect_cmd(d[0], 1'b1, 1'b0), got);
    expect_no_cmd(10);
    stop = 1'b0;
    for (n = 1; n < 3; n++)
    begin
      serve_command(got);
      compare_cmd($sformatf("cmd %0d", n), expect_cmd(d[n], 1'b0, 1'b0), got);
    end
    for (n = 0; n < 3; n++)
      send_response({1'b0, 8'h00});
    compare_status("status", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  task automatic test_back_pressure();
    logic [255:0] d [5];
    write_cmd_t   got;
    int           n;
    start_test("back_pressure");
    stop = 1'b1;
    for (n = 0; n < 4; n++)
    begin
      d[n] = rand_desc();
      send_descriptor(d[n]);
    end
    d[4]      = rand_desc();
    desc_data = d[4];
    desc_req  = 1'b1;
    for (n = 0; n < 10; n++)
    begin
      tick();
      compare_bit("desc_ack while full", 1'b0, desc_ack);
    end
    stop = 1'b0;
    n    = 0;
    while (desc_ack !== 1'b1 && n < 20)
    begin
      tick();
      n++;
    end
    if (desc_ack !== 1'b1)
    begin
      $display("%s: desc_ack never rose after a slot was freed", test_name);
      err_count++;
    end
    seq_q.push_back(d[4][111:96]);
    desc_req = 1'b0;
    while (desc_ack !== 1'b0)
      tick();
    for (n = 0; n < 5; n++)
    begin
      serve_command(got);
      compare_cmd($sformatf("cmd %0d", n), expect_cmd(d[n], 1'b0, 1'b0), got);
      send_response({1'b0, 8'h00});
    end
    compare_status("status", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  task automatic irq_case(input string what, input logic tc, input logic et,
                          input logic [7:0] err_mask, input write_rsp_t r,
                          input logic exp_irq);
    logic [255:0] d;
    write_cmd_t   got;
    d = with_masks(rand_desc(), tc, et, err_mask);
    send_descriptor(d);
    serve_command(got);
    compare_cmd(what, expect_cmd(d, 1'b0, 1'b0), got);
    send_response(r);
    compare_bit(what, exp_irq, irq);
    clear_irq();
    compare_bit("irq after clear", 1'b0, irq);
  endtask

  task automatic test_irq_masks();
    start_test("irq_masks");
    clear_irq();
    compare_bit("irq at start", 1'b0, irq);
    irq_case("complete masked", 1'b1, 1'b0, 8'h00, {1'b0, 8'h00}, 1'b1);
    irq_case("nothing masked", 1'b0, 1'b0, 8'h00, {1'b1, 8'h04}, 1'b0);
    irq_case("error outside mask", 1'b0, 1'b0, 8'h0f, {1'b0, 8'hf0}, 1'b0);
    irq_case("error inside mask", 1'b0, 1'b0, 8'h0f, {1'b0, 8'h03}, 1'b1);
    irq_case("early end masked", 1'b0, 1'b1, 8'h00, {1'b1, 8'h00}, 1'b1);
    compare_status("status", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  task automatic test_status_reset();
    logic [255:0] d;
    write_cmd_t   got;
    int           n;
    start_test("status_reset");
    d = rand_desc();
    send_descriptor(d);
    serve_command(got);
    compare_cmd("cmd", expect_cmd(d, 1'b0, 1'b0), got);
    send_response({1'b0, 8'h00});
    compare_status("status after response", status_expect(1'b0, 4'd0), status);
    stop = 1'b1;
    for (n = 0; n < 3; n++)
      send_descriptor(rand_desc());
    compare_status("status while queued", status_expect(1'b1, 4'd3), status);
    sw_reset = 1'b1;
    tick();
    tick();
    sw_reset = 1'b0;
    stop     = 1'b0;
    seq_q.delete();
    exp_completed = 16'd0;
    exp_error     = 8'h00;
    exp_last_seq  = 16'd0;
    compare_status("status after sw_reset", status_expect(1'b0, 4'd0), status);
    expect_no_cmd(10);
    d = rand_desc();
    send_descriptor(d);
    serve_command(got);
    compare_cmd("cmd after sw_reset", expect_cmd(d, 1'b0, 1'b0), got);
    send_response({1'b0, 8'h00});
    compare_status("status at end", status_expect(1'b0, 4'd0), status);
    end_test();
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    seed          = 32'heb962b4c;
    cycle_count   = 0;
    err_count     = 0;
    pass_count    = 0;
    exp_completed = 16'd0;
    exp_error     = 8'h00;
    exp_last_seq  = 16'd0;
    clk           = 1'b0;
    rst_n         = 1'b0;
    stop          = 1'b0;
    sw_reset      = 1'b0;
    irq_clear     = 1'b0;
    desc_req      = 1'b0;
    desc_data     = '0;
    cmd_ack       = 1'b0;
    rsp_req       = 1'b0;
    rsp           = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_after_reset();
    test_field_decode();
    test_order_stop();
    test_back_pressure();
    test_irq_masks();
    test_status_reset();

    $display("%0d tests passed, %0d errors", pass_count, err_count);
    if (err_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/dma_pkg.sv
src/descriptor_fifo.sv
src/write_descriptor_decode.sv
src/write_command_issue.sv
src/write_response_irq.sv
src/write_dispatcher.sv
sim/tb_write_dispatcher.sv

// File: src/descriptor_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module descriptor_fifo #(
  parameter int DESC_WIDTH = dma_pkg::EXT_DESC_WIDTH,
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  flush,
  input  wire logic                  desc_req,
  input  wire logic [DESC_WIDTH-1:0] desc_data,
  input  wire logic                  fifo_pop,
  output logic                       desc_ack,
  output logic                       fifo_valid,
  output logic [DESC_WIDTH-1:0]      fifo_data,
  output logic [3:0]                 fifo_count
);

  import dma_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [DESC_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  fifo_in_state_t        in_state;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full       = (fifo_count == 4'(FIFO_DEPTH));
  assign push       = (in_state == WAIT_REQ) && desc_req && !full && !flush;
  assign pop        = fifo_pop && fifo_valid;
  assign fifo_valid = (fifo_count != 4'd0);
  assign fifo_data  = mem[rd_ptr];

  // ----------------------------------------------------------
  // Four-phase input side
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_state <= WAIT_REQ;
      desc_ack <= 1'b0;
    end
    else
    begin
      case (in_state)
        WAIT_REQ:
        begin
          // Held off here while full
          if (push)
          begin
            desc_ack <= 1'b1;
            in_state <= WAIT_DROP;
          end
        end
        WAIT_DROP:
        begin
          if (!desc_req)
          begin
            desc_ack <= 1'b0;
            in_state <= WAIT_REQ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= desc_data;
  end

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= 4'd0;
    end
    else if (flush)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= 4'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 4'd1;
        2'b01:   fifo_count <= fifo_count - 4'd1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/dma_pkg.sv
`default_nettype none

package dma_pkg;

  // ----------------------------------------------------------
  // Descriptor widths
  // ----------------------------------------------------------
  localparam int EXT_DESC_WIDTH = 256;
  localparam int STD_DESC_WIDTH = 128;

  // ----------------------------------------------------------
  // Command, response and status records
  // ----------------------------------------------------------

  // Command as seen by the write master
  typedef struct packed {
    logic [63:0] address;
    logic [31:0] length;
    logic [7:0]  burst_count;
    logic [15:0] stride;
    logic [15:0] sequence_number;
    logic        park;
    logic        end_on_eop;
    logic        stop;
    logic        sw_reset;
  } write_cmd_t;

  // One in-flight table entry
  typedef struct packed {
    logic        transfer_complete;
    logic        early_termination;
    logic [7:0]  error;
    logic [15:0] sequence_number;
  } irq_mask_t;

  typedef struct packed {
    logic       early_termination;
    logic [7:0] error;
  } write_rsp_t;

  typedef struct packed {
    logic        busy;
    logic [3:0]  pending;
    logic [15:0] completed;
    logic [7:0]  error_latched;
    logic [15:0] last_sequence;
  } dispatch_status_t;

  // ----------------------------------------------------------
  // State encodings
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    REQ,
    WAIT_LOW
  } issue_state_t;

  typedef enum logic {
    WAIT_REQ,
    WAIT_DROP
  } fifo_in_state_t;

endpackage

`default_nettype wire

// File: src/write_command_issue.sv
`timescale 1ns/10ps
`default_nettype none

module write_command_issue (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                stop,
  input  wire logic                sw_reset,
  input  wire logic                fifo_valid,
  input  wire dma_pkg::write_cmd_t decoded_cmd,
  input  wire dma_pkg::irq_mask_t  decoded_masks,
  input  wire logic                table_full,
  input  wire logic                cmd_ack,
  output logic                     fifo_pop,
  output logic                     cmd_req,
  output dma_pkg::write_cmd_t      cmd,
  output logic                     cmd_issued,
  output dma_pkg::irq_mask_t       issued_masks
);

  import dma_pkg::*;

  issue_state_t state;

  // Head is taken during LOAD unless a flush is under way
  assign fifo_pop = (state == LOAD) && !sw_reset;

  // ----------------------------------------------------------
  // Issue FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      cmd_req    <= 1'b0;
      cmd_issued <= 1'b0;
    end
    else
    begin
      cmd_issued <= 1'b0;
      case (state)
        IDLE:
        begin
          if (fifo_valid && !stop && !sw_reset && !table_full)
            state <= LOAD;
        end
        LOAD:
        begin
          if (sw_reset)
            state <= IDLE;
          else
            state <= REQ;
        end
        REQ:
        begin
          if (!cmd_req)
          begin
            // Nothing open yet, so a reset can still drop the command
            if (sw_reset)
              state <= IDLE;
            else
              cmd_req <= 1'b1;
          end
          else if (cmd_ack)
          begin
            cmd_req    <= 1'b0;
            cmd_issued <= 1'b1;
            state      <= WAIT_LOW;
          end
        end
        WAIT_LOW:
        begin
          if (!cmd_ack)
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Held stable for the whole exchange
  always_ff @(posedge clk)
  begin
    if (fifo_pop)
    begin
      cmd          <= decoded_cmd;
      issued_masks <= decoded_masks;
    end
  end

endmodule

`default_nettype wire

// File: src/write_descriptor_decode.sv
`timescale 1ns/10ps
`default_nettype none

module write_descriptor_decode #(
  parameter int DESC_WIDTH = dma_pkg::EXT_DESC_WIDTH
) (
  input  wire logic [DESC_WIDTH-1:0] descriptor,
  input  wire logic                  stop,
  input  wire logic                  sw_reset,
  output dma_pkg::write_cmd_t        cmd,
  output dma_pkg::irq_mask_t         masks,
  output logic [255:0]               command_word
);

  import dma_pkg::*;

  logic [31:0] address_hi;
  logic [7:0]  burst_count;
  logic [15:0] stride;
  logic [15:0] sequence_number;
  logic        park;
  logic        end_on_eop;
  logic        tc_mask;
  logic        et_mask;
  logic [7:0]  error_mask;

  // ----------------------------------------------------------
  // Layout dependent fields
  // ----------------------------------------------------------
  generate
    if (DESC_WIDTH == EXT_DESC_WIDTH)
    begin : g_ext
      assign park            = descriptor[235];
      assign end_on_eop      = descriptor[236];
      assign tc_mask         = descriptor[238];
      assign et_mask         = descriptor[239];
      assign error_mask      = descriptor[247:240];
      assign burst_count     = descriptor[127:120];
      assign stride          = descriptor[159:144];
      assign sequence_number = descriptor[111:96];
      assign address_hi      = descriptor[223:192];
    end
    else
    begin : g_std
      logic [STD_DESC_WIDTH-1:0] std_desc;

      assign std_desc        = descriptor[STD_DESC_WIDTH-1:0];
      assign park            = std_desc[107];
      assign end_on_eop      = std_desc[108];
      assign tc_mask         = std_desc[110];
      assign et_mask         = std_desc[111];
      assign error_mask      = std_desc[119:112];
      // No room for these in the short layout
      assign burst_count     = 8'h00;
      assign stride          = 16'h0000;
      assign sequence_number = 16'h0000;
      assign address_hi      = 32'h0000_0000;
    end
  endgenerate

  always_comb
  begin
    cmd.address         = {address_hi, descriptor[63:32]};
    cmd.length          = descriptor[95:64];
    cmd.burst_count     = burst_count;
    cmd.stride          = stride;
    cmd.sequence_number = sequence_number;
    cmd.park            = park;
    cmd.end_on_eop      = end_on_eop;
    cmd.stop            = stop;
    cmd.sw_reset        = sw_reset;

    masks.transfer_complete = tc_mask;
    masks.early_termination = et_mask;
    masks.error             = error_mask;
    masks.sequence_number   = sequence_number;
  end

  // Debug copy of the command in master word order
  assign command_word = {{132{1'b0}},
                         address_hi,
                         stride,
                         burst_count,
                         sw_reset,
                         stop,
                         1'b0,
                         end_on_eop,
                         descriptor[95:64],
                         descriptor[63:32]};

endmodule

`default_nettype wire

// File: src/write_dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module write_dispatcher #(
  parameter int DESC_WIDTH     = dma_pkg::EXT_DESC_WIDTH,
  parameter int FIFO_DEPTH     = 4,
  parameter int INFLIGHT_DEPTH = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  stop,
  input  wire logic                  sw_reset,
  input  wire logic                  irq_clear,
  input  wire logic                  desc_req,
  input  wire logic [DESC_WIDTH-1:0] desc_data,
  input  wire logic                  cmd_ack,
  input  wire logic                  rsp_req,
  input  wire dma_pkg::write_rsp_t   rsp,
  output logic                       desc_ack,
  output logic                       cmd_req,
  output dma_pkg::write_cmd_t        cmd,
  output logic [255:0]               command_word,
  output logic                       rsp_ack,
  output logic                       irq,
  output dma_pkg::dispatch_status_t  status
);

  import dma_pkg::*;

  logic                  fifo_valid;
  logic                  fifo_pop;
  logic [DESC_WIDTH-1:0] fifo_data;
  logic [3:0]            fifo_count;
  write_cmd_t            decoded_cmd;
  irq_mask_t             decoded_masks;
  irq_mask_t             issued_masks;
  logic                  cmd_issued;
  logic                  table_full;

  // ----------------------------------------------------------
  // Descriptor path
  // ----------------------------------------------------------
  descriptor_fifo #(
    .DESC_WIDTH (DESC_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_descriptor_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (sw_reset),
    .desc_req   (desc_req),
    .desc_data  (desc_data),
    .fifo_pop   (fifo_pop),
    .desc_ack   (desc_ack),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_count (fifo_count)
  );

  write_descriptor_decode #(
    .DESC_WIDTH (DESC_WIDTH)
  ) u_write_descriptor_decode (
    .descriptor   (fifo_data),
    .stop         (stop),
    .sw_reset     (sw_reset),
    .cmd          (decoded_cmd),
    .masks        (decoded_masks),
    .command_word (command_word)
  );

  // ----------------------------------------------------------
  // Master side
  // ----------------------------------------------------------
  write_command_issue u_write_command_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .stop          (stop),
    .sw_reset      (sw_reset),
    .fifo_valid    (fifo_valid),
    .decoded_cmd   (decoded_cmd),
    .decoded_masks (decoded_masks),
    .table_full    (table_full),
    .cmd_ack       (cmd_ack),
    .fifo_pop      (fifo_pop),
    .cmd_req       (cmd_req),
    .cmd           (cmd),
    .cmd_issued    (cmd_issued),
    .issued_masks  (issued_masks)
  );

  write_response_irq #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
  ) u_write_response_irq (
    .clk          (clk),
    .rst_n        (rst_n),
    .sw_reset     (sw_reset),
    .cmd_issued   (cmd_issued),
    .issued_masks (issued_masks),
    .rsp_req      (rsp_req),
    .rsp          (rsp),
    .irq_clear    (irq_clear),
    .fifo_count   (fifo_count),
    .rsp_ack      (rsp_ack),
    .table_full   (table_full),
    .irq          (irq),
    .status       (status)
  );

endmodule

`default_nettype wire

// File: src/write_response_irq.sv
`timescale 1ns/10ps
`default_nettype none

module write_response_irq #(
  parameter int INFLIGHT_DEPTH = 4
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                sw_reset,
  input  wire logic                cmd_issued,
  input  wire dma_pkg::irq_mask_t  issued_masks,
  input  wire logic                rsp_req,
  input  wire dma_pkg::write_rsp_t rsp,
  input  wire logic                irq_clear,
  input  wire logic [3:0]          fifo_count,
  output logic                     rsp_ack,
  output logic                     table_full,
  output logic                     irq,
  output dma_pkg::dispatch_status_t status
);

  import dma_pkg::*;

  localparam int PTR_W = (INFLIGHT_DEPTH > 1) ? $clog2(INFLIGHT_DEPTH) : 1;
  localparam int CNT_W = $clog2(INFLIGHT_DEPTH + 1);

  irq_mask_t        table_q [INFLIGHT_DEPTH];
  irq_mask_t        head_rec;
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] used;
  logic             accept;
  logic             push;
  logic             pop;
  logic             irq_hit;
  logic [15:0]      completed;
  logic [7:0]       error_latched;
  logic [15:0]      last_sequence;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(INFLIGHT_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign accept     = rsp_req && !rsp_ack;
  assign push       = cmd_issued && !table_full && !sw_reset;
  assign pop        = accept && (used != '0) && !sw_reset;
  assign head_rec   = table_q[head];
  assign table_full = (used == CNT_W'(INFLIGHT_DEPTH));

  // Interrupt rule against the oldest outstanding command
  assign irq_hit = (head_rec.transfer_complete && !rsp.early_termination)
                || (head_rec.early_termination && rsp.early_termination)
                || ((rsp.error & head_rec.error) != 8'h00);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rsp_ack <= 1'b0;
    else if (accept)
      rsp_ack <= 1'b1;
    else if (rsp_ack && !rsp_req)
      rsp_ack <= 1'b0;
  end

  // ----------------------------------------------------------
  // In-flight table
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (push)
      table_q[tail] <= issued_masks;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || sw_reset)
    begin
      head <= '0;
      tail <= '0;
      used <= '0;
    end
    else
    begin
      if (push)
        tail <= next_ptr(tail);
      if (pop)
        head <= next_ptr(head);
      if (push && !pop)
        used <= used + 1'b1;
      else if (pop && !push)
        used <= used - 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Status and interrupt
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n || sw_reset)
    begin
      completed     <= 16'd0;
      error_latched <= 8'h00;
      last_sequence <= 16'd0;
    end
    else
    begin
      if (accept)
        error_latched <= error_latched | rsp.error;
      if (pop)
      begin
        completed     <= completed + 16'd1;
        last_sequence <= head_rec.sequence_number;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      irq <= 1'b0;
    else if (pop && irq_hit)
      irq <= 1'b1;
    else if (irq_clear)
      irq <= 1'b0;
  end

  always_comb
  begin
    status.busy          = (used != '0) || (fifo_count != 4'd0);
    status.pending       = fifo_count;
    status.completed     = completed;
    status.error_latched = error_latched;
    status.last_sequence = last_sequence;
  end

endmodule

`default_nettype wire
